/* source/bridge_pkg.sv */
package bridge_pkg;

    // Start bytes for the two frame directions
    localparam logic [7:0] SOF_HOST   = 8'hA5;
    localparam logic [7:0] SOF_DEVICE = 8'h5A;

    // Largest payload one command can move
    localparam int MAX_BYTES = 8;

    // Meaning of CMD bit 7
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } opcode_e;

    typedef enum logic [7:0] {
        ST_OK       = 8'h00,
        ST_CRC_ERR  = 8'h01,
        ST_ADDR_ERR = 8'h02,
        ST_CMD_ERR  = 8'h03
    } status_e;

    // Decoded host command, byte 0 of data in the low bits
    typedef struct packed {
        logic [7:0]             cmd;
        opcode_e                op;
        logic [3:0]             len;
        logic [31:0]            addr;
        logic [MAX_BYTES*8-1:0] data;
        status_e                status;
    } cmd_t;

    // Result handed from the executor to the frame builder
    typedef struct packed {
        status_e                status;
        logic [7:0]             cmd;
        logic [31:0]            addr;
        logic [3:0]             len;
        logic [MAX_BYTES*8-1:0] data;
    } resp_t;

endpackage

/* source/crc8_calc.sv */
`timescale 1ns/1ps

module crc8_calc (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear,
    input  logic       enable,
    input  logic [7:0] data_in,
    output logic [7:0] crc
);

    logic [7:0] next_crc;

    // One byte through polynomial 0x07, MSB first
    always_comb begin
        next_crc = crc ^ data_in;
        for (int i = 0; i < 8; i++) begin
            if (next_crc[7]) begin
                next_crc = (next_crc << 1) ^ 8'h07;
            end else begin
                next_crc = next_crc << 1;
            end
        end
    end

    // Clear has priority over a folded byte
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc <= 8'h00;
        end else if (enable) begin
            crc <= next_crc;
        end
    end

endmodule

/* source/cmd_frame_parser.sv */
`timescale 1ns/1ps

module cmd_frame_parser (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        rx_data,
    input  logic              rx_valid,
    output logic              rx_ready,
    output logic              cmd_req,
    input  logic              cmd_ack,
    output bridge_pkg::cmd_t  cmd
);
    import bridge_pkg::*;

    typedef enum logic [2:0] {
        SOF,
        CMD,
        ADDR,
        DATA,
        CRC,
        OFFER
    } state_e;

    state_e     state;
    logic [2:0] byte_idx;
    logic       take;
    logic [7:0] crc;
    cmd_t       cmd_q;

    // Input is stalled while a command is on offer
    assign rx_ready = (state != OFFER);
    assign take     = rx_valid && rx_ready;
    assign cmd      = cmd_q;

    // CRC restarts on every byte seen while hunting for SOF
    crc8_calc u_crc (
        .clk     (clk),
        .rst     (rst),
        .clear   (state == SOF),
        .enable  (take && (state == CMD || state == ADDR || state == DATA)),
        .data_in (rx_data),
        .crc     (crc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SOF;
            byte_idx <= 3'd0;
            cmd_req  <= 1'b0;
        end else begin
            case (state)
                SOF: begin
                    if (take && rx_data == SOF_HOST) begin
                        state <= CMD;
                    end
                end
                CMD: begin
                    if (take) begin
                        byte_idx <= 3'd0;
                        state    <= ADDR;
                    end
                end
                ADDR: begin
                    if (take) begin
                        byte_idx <= byte_idx + 3'd1;
                        if (byte_idx == 3'd3) begin
                            byte_idx <= 3'd0;
                            // Reads carry no data bytes
                            state    <= (cmd_q.op == OP_READ) ? CRC : DATA;
                        end
                    end
                end
                DATA: begin
                    if (take) begin
                        byte_idx <= byte_idx + 3'd1;
                        if ({1'b0, byte_idx} == cmd_q.len - 4'd1) begin
                            state <= CRC;
                        end
                    end
                end
                CRC: begin
                    if (take) begin
                        cmd_req <= 1'b1;
                        state   <= OFFER;
                    end
                end
                OFFER: begin
                    if (cmd_req && cmd_ack) begin
                        cmd_req <= 1'b0;
                    end else if (!cmd_req && !cmd_ack) begin
                        state <= SOF;
                    end
                end
                default: state <= SOF;
            endcase
        end
    end

    // Command fields, loaded byte by byte
    always_ff @(posedge clk) begin
        if (take) begin
            case (state)
                CMD: begin
                    cmd_q.cmd  <= rx_data;
                    cmd_q.op   <= opcode_e'(rx_data[7]);
                    cmd_q.len  <= {1'b0, rx_data[2:0]} + 4'd1;
                    cmd_q.data <= '0;
                end
                ADDR: cmd_q.addr[byte_idx*8 +: 8] <= rx_data;
                DATA: cmd_q.data[byte_idx*8 +: 8] <= rx_data;
                CRC: begin
                    if (rx_data != crc) begin
                        cmd_q.status <= ST_CRC_ERR;
                    end else if (cmd_q.cmd[6:3] != 4'd0) begin
                        cmd_q.status <= ST_CMD_ERR;
                    end else begin
                        cmd_q.status <= ST_OK;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Executor samples the command at any point of the handshake
    a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
        cmd_req |=> !cmd_req || $stable(cmd))
        else $error("cmd changed while cmd_req was high");

endmodule

/* source/reg_executor.sv */
`timescale 1ns/1ps

module reg_executor #(
    parameter int MEM_DEPTH = 256
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_req,
    output logic              cmd_ack,
    input  bridge_pkg::cmd_t  cmd,
    output logic              resp_req,
    input  logic              resp_ack,
    output bridge_pkg::resp_t resp
);
    import bridge_pkg::*;

    localparam int AW = $clog2(MEM_DEPTH);

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        RAISE,
        OFFER
    } state_e;

    state_e      state;
    logic [7:0]  mem [MEM_DEPTH];
    logic [32:0] end_addr;
    logic [AW-1:0] base;
    status_e     result;
    logic        accept;
    logic        do_access;
    resp_t       resp_q;

    assign end_addr  = {1'b0, cmd.addr} + 33'(cmd.len);
    assign base      = cmd.addr[AW-1:0];
    assign accept    = (state == IDLE) && cmd_req;
    assign do_access = accept && (result == ST_OK);
    assign resp      = resp_q;

    // Parser errors win over the range check
    always_comb begin
        if (cmd.status != ST_OK) begin
            result = cmd.status;
        end else if (end_addr > 33'(MEM_DEPTH)) begin
            result = ST_ADDR_ERR;
        end else begin
            result = ST_OK;
        end
    end

    // Memory access happens in the cycle cmd_ack rises
    always_ff @(posedge clk) begin
        if (accept) begin
            resp_q.status <= result;
            resp_q.cmd    <= cmd.cmd;
            resp_q.addr   <= cmd.addr;
            resp_q.len    <= cmd.len;
            resp_q.data   <= '0;
            for (int i = 0; i < MAX_BYTES; i++) begin
                if (do_access && i < int'(cmd.len)) begin
                    if (cmd.op == OP_READ) begin
                        resp_q.data[i*8 +: 8] <= mem[base + AW'(i)];
                    end else begin
                        mem[base + AW'(i)] <= cmd.data[i*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            cmd_ack  <= 1'b0;
            resp_req <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        cmd_ack <= 1'b1;
                        state   <= ACK;
                    end
                end
                ACK: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= RAISE;
                    end
                end
                RAISE: begin
                    resp_req <= 1'b1;
                    state    <= OFFER;
                end
                OFFER: begin
                    // No new command until the builder has let go of ack
                    if (resp_req && resp_ack) begin
                        resp_req <= 1'b0;
                    end else if (!resp_req && !resp_ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_req_after_ack_low: assert property (@(posedge clk) disable iff (rst)
        $rose(resp_req) |-> !resp_ack)
        else $error("resp_req rose while resp_ack was still high");

endmodule

/* source/resp_frame_builder.sv */
`timescale 1ns/1ps

module resp_frame_builder (
    input  logic              clk,
    input  logic              rst,
    input  logic              resp_req,
    output logic              resp_ack,
    input  bridge_pkg::resp_t resp,
    output logic [7:0]        fifo_wdata,
    output logic              fifo_wr,
    input  logic              fifo_full,
    output logic              frame_done
);
    import bridge_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        SOF,
        STATUS,
        CMD,
        ADDR,
        DATA,
        CRC,
        DONE,
        GAP
    } state_e;

    state_e     state;
    state_e     state_next;
    resp_t      resp_q;
    logic [2:0] byte_idx;
    logic [7:0] out_byte;
    logic [7:0] crc;
    logic       with_payload;
    logic       addr_last;
    logic       data_last;
    logic       sending;

    // Address and data only go out for a good read
    assign with_payload = (resp_q.status == ST_OK) && (opcode_e'(resp_q.cmd[7]) == OP_READ);
    assign addr_last    = (byte_idx == 3'd3);
    assign data_last    = ({1'b0, byte_idx} == resp_q.len - 4'd1);

    assign sending    = (state == SOF) || (state == STATUS) || (state == CMD) ||
                        (state == ADDR) || (state == DATA) || (state == CRC);
    assign fifo_wr    = sending && !fifo_full;
    assign fifo_wdata = out_byte;
    assign frame_done = (state == DONE);

    crc8_calc u_crc (
        .clk     (clk),
        .rst     (rst),
        .clear   (state == IDLE),
        .enable  (fifo_wr && state != SOF && state != CRC),
        .data_in (out_byte),
        .crc     (crc)
    );

    always_comb begin
        case (state)
            SOF:     out_byte = SOF_DEVICE;
            STATUS:  out_byte = resp_q.status;
            CMD:     out_byte = resp_q.cmd;
            ADDR:    out_byte = resp_q.addr[byte_idx*8 +: 8];
            DATA:    out_byte = resp_q.data[byte_idx*8 +: 8];
            CRC:     out_byte = crc;
            default: out_byte = 8'h00;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // Frame starts only after the handshake has closed
                if (resp_ack && !resp_req) begin
                    state_next = SOF;
                end
            end
            SOF:    if (fifo_wr) state_next = STATUS;
            STATUS: if (fifo_wr) state_next = CMD;
            CMD:    if (fifo_wr) state_next = with_payload ? ADDR : CRC;
            ADDR:   if (fifo_wr && addr_last) state_next = DATA;
            DATA:   if (fifo_wr && data_last) state_next = CRC;
            CRC:    if (fifo_wr) state_next = DONE;
            DONE:   state_next = GAP;
            GAP:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            resp_ack <= 1'b0;
            byte_idx <= 3'd0;
        end else begin
            state <= state_next;
            if (state == IDLE) begin
                if (resp_req && !resp_ack) begin
                    resp_ack <= 1'b1;
                end else if (resp_ack && !resp_req) begin
                    resp_ack <= 1'b0;
                end
            end
            if (fifo_wr && state == ADDR) begin
                byte_idx <= addr_last ? 3'd0 : byte_idx + 3'd1;
            end
            if (fifo_wr && state == DATA) begin
                byte_idx <= data_last ? 3'd0 : byte_idx + 3'd1;
            end
        end
    end

    // Response copy taken as ack goes up
    always_ff @(posedge clk) begin
        if (state == IDLE && resp_req && !resp_ack) begin
            resp_q <= resp;
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        fifo_full |-> !fifo_wr)
        else $error("builder wrote into a full FIFO");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        frame_done |=> !frame_done)
        else $error("frame_done held longer than one cycle");

endmodule

/* source/tx_byte_fifo.sv */
`timescale 1ns/1ps

module tx_byte_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] wdata,
    input  logic       wr,
    output logic       full,
    output logic [7:0] rdata,
    input  logic       rd,
    output logic       empty
);

    localparam int PW = $clog2(FIFO_DEPTH);

    logic [7:0]  buf_mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0] count;
    logic        push;
    logic        pop;

    assign full  = (count == (PW+1)'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign push  = wr && !full;
    assign pop   = rd && !empty;
    // Head byte is visible without a read
    assign rdata = buf_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            buf_mem[wr_ptr] <= wdata;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        full |-> !wr)
        else $error("write attempted while FIFO full");

endmodule

/* source/bridge_top.sv */
`timescale 1ns/1ps

module bridge_top #(
    parameter int MEM_DEPTH  = 256,
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic       rx_ready,
    output logic [7:0] tx_data,
    output logic       tx_empty,
    input  logic       tx_rd,
    output logic       frame_done
);
    import bridge_pkg::*;

    logic       cmd_req;
    logic       cmd_ack;
    cmd_t       cmd;
    logic       resp_req;
    logic       resp_ack;
    resp_t      resp;
    logic [7:0] fifo_wdata;
    logic       fifo_wr;
    logic       fifo_full;

    cmd_frame_parser u_parser (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .cmd      (cmd)
    );

    reg_executor #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_executor (
        .clk      (clk),
        .rst      (rst),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .cmd      (cmd),
        .resp_req (resp_req),
        .resp_ack (resp_ack),
        .resp     (resp)
    );

    resp_frame_builder u_builder (
        .clk        (clk),
        .rst        (rst),
        .resp_req   (resp_req),
        .resp_ack   (resp_ack),
        .resp       (resp),
        .fifo_wdata (fifo_wdata),
        .fifo_wr    (fifo_wr),
        .fifo_full  (fifo_full),
        .frame_done (frame_done)
    );

    tx_byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_tx_fifo (
        .clk   (clk),
        .rst   (rst),
        .wdata (fifo_wdata),
        .wr    (fifo_wr),
        .full  (fifo_full),
        .rdata (tx_data),
        .rd    (tx_rd),
        .empty (tx_empty)
    );

endmodule

/* verification/bridge_tb.sv */
`timescale 1ns/1ps

module bridge_tb;

    localparam int MEM_DEPTH  = 256;
    localparam int FIFO_DEPTH = 16;
    localparam int TIMEOUT    = 2000;

    localparam logic [7:0] HOST_SOF    = 8'hA5;
    localparam logic [7:0] DEV_SOF     = 8'h5A;
    localparam logic [7:0] ST_OK       = 8'h00;
    localparam logic [7:0] ST_CRC_ERR  = 8'h01;
    localparam logic [7:0] ST_ADDR_ERR = 8'h02;
    localparam logic [7:0] ST_CMD_ERR  = 8'h03;

    logic       clk;
    logic       rst;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_ready;
    logic [7:0] tx_data;
    logic       tx_empty;
    logic       tx_rd;
    logic       frame_done;

    // Reference copy of the register bytes
    logic [7:0] model_mem [MEM_DEPTH];
    int         wr_addr [6];
    int         wr_len [6];
    integer     seed;
    int         errors;
    int         tests_run;
    int         tests_failed;
    int         done_count;
    bit         timed_out;
    string      test_name;

    bridge_top #(
        .MEM_DEPTH  (MEM_DEPTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .tx_data    (tx_data),
        .tx_empty   (tx_empty),
        .tx_rd      (tx_rd),
        .frame_done (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        if (frame_done) begin
            done_count++;
        end
    end

    // CRC-8, poly 0x07, one bit at a time from the MSB
    function automatic logic [7:0] crc_update(input logic [7:0] crc, input logic [7:0] b);
        logic [7:0] c;
        logic       fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[7] ^ b[i];
            c  = {c[6:0], 1'b0};
            if (fb) begin
                c = c ^ 8'h07;
            end
        end
        return c;
    endfunction

    function automatic logic [63:0] model_bytes(input int addr, input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r[i*8 +: 8] = model_mem[addr + i];
        end
        return r;
    endfunction

    task automatic check_byte(input string field, input logic [7:0] exp, input logic [7:0] act);
        if (!timed_out && act !== exp) begin
            $display("Mismatch %s %s: expected %h actual %h", test_name, field, exp, act);
            errors++;
        end
    endtask

    // Called at a falling edge, returns at the falling edge after the byte is taken
    task automatic send_byte(input logic [7:0] b);
        int waited;
        if (timed_out) return;
        waited   = 0;
        rx_data  = b;
        rx_valid = 1'b1;
        while (!rx_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!rx_ready) begin
            $display("%s: rx_ready stayed low, byte %h was never taken", test_name, b);
            errors++;
            timed_out = 1'b1;
        end
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic send_frame(input logic [7:0] cmd, input logic [31:0] addr,
                              input logic [63:0] data, input bit corrupt);
        logic [7:0] crc;
        int         n;
        crc = 8'h00;
        n   = cmd[2:0] + 1;
        send_byte(HOST_SOF);
        send_byte(cmd);
        crc = crc_update(crc, cmd);
        for (int i = 0; i < 4; i++) begin
            send_byte(addr[i*8 +: 8]);
            crc = crc_update(crc, addr[i*8 +: 8]);
        end
        if (!cmd[7]) begin
            for (int i = 0; i < n; i++) begin
                send_byte(data[i*8 +: 8]);
                crc = crc_update(crc, data[i*8 +: 8]);
            end
        end
        send_byte(corrupt ? (crc ^ 8'h5C) : crc);
    endtask

    task automatic pop_byte(output logic [7:0] b);
        int waited;
        b = 8'h00;
        if (timed_out) return;
        waited = 0;
        while (tx_empty && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (tx_empty) begin
            $display("%s: TX FIFO stayed empty while a response byte was due", test_name);
            errors++;
            timed_out = 1'b1;
            return;
        end
        b     = tx_data;
        tx_rd = 1'b1;
        @(negedge clk);
        tx_rd = 1'b0;
    endtask

    // Frame length follows the received status, as a host would parse it
    task automatic collect_resp(input logic [7:0] exp_status, input logic [7:0] cmd,
                                input logic [31:0] addr, input logic [63:0] exp_data,
                                input bit single);
        logic [7:0] b;
        logic [7:0] status;
        logic [7:0] crc;
        int         n;
        int         exp_len;
        int         act_len;
        n       = cmd[2:0] + 1;
        exp_len = (exp_status == ST_OK && cmd[7]) ? 8 + n : 4;
        crc     = crc_update(8'h00, exp_status);
        crc     = crc_update(crc, cmd);
        pop_byte(b);
        check_byte("SOF", DEV_SOF, b);
        pop_byte(status);
        check_byte("STATUS", exp_status, status);
        pop_byte(b);
        check_byte("CMD", cmd, b);
        act_len = 3;
        if (status == ST_OK && cmd[7]) begin
            for (int i = 0; i < 4; i++) begin
                pop_byte(b);
                check_byte("ADDR", addr[i*8 +: 8], b);
                crc = crc_update(crc, addr[i*8 +: 8]);
            end
            for (int i = 0; i < n; i++) begin
                pop_byte(b);
                check_byte("DATA", exp_data[i*8 +: 8], b);
                crc = crc_update(crc, exp_data[i*8 +: 8]);
            end
            act_len += 4 + n;
        end
        pop_byte(b);
        check_byte("CRC", crc, b);
        act_len++;
        // With no other frame queued, any byte left in the FIFO belongs to this one
        if (single) begin
            for (int i = 0; i < FIFO_DEPTH && !timed_out && !tx_empty; i++) begin
                pop_byte(b);
                act_len++;
            end
        end
        if (!timed_out && act_len != exp_len) begin
            $display("Mismatch %s length: expected %0d actual %0d", test_name, exp_len, act_len);
            errors++;
        end
    endtask

    task automatic write_regs(input int addr, input int n, input logic [63:0] data);
        logic [7:0] cmd;
        cmd = 8'(n - 1);
        send_frame(cmd, addr, data, 1'b0);
        collect_resp(ST_OK, cmd, addr, 64'h0, 1'b1);
        for (int i = 0; i < n; i++) begin
            model_mem[addr + i] = data[i*8 +: 8];
        end
    endtask

    task automatic read_regs(input int addr, input int n);
        logic [7:0] cmd;
        cmd = 8'h80 | 8'(n - 1);
        send_frame(cmd, addr, 64'h0, 1'b0);
        collect_resp(ST_OK, cmd, addr, model_bytes(addr, n), 1'b1);
    endtask

    task automatic report_test(input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: pass", test_name);
        end else begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", test_name, errors - errors_before);
        end
    endtask

    task automatic idle_after_reset();
        int e0;
        test_name = "reset_state";
        e0 = errors;
        check_byte("tx_empty", 8'h01, {7'b0, tx_empty});
        check_byte("rx_ready", 8'h01, {7'b0, rx_ready});
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (frame_done) begin
                $display("%s: frame_done pulsed with no command sent", test_name);
                errors++;
            end
        end
        report_test(e0);
    endtask

    task automatic random_write_read();
        int          e0;
        int          n;
        logic [63:0] fill;
        test_name = "write_read";
        e0 = errors;
        // Whole memory gets an address-derived pattern first
        for (int a = 0; a < MEM_DEPTH; a += 8) begin
            for (int i = 0; i < 8; i++) begin
                fill[i*8 +: 8] = 8'((a + i) * 37 + 91);
            end
            write_regs(a, 8, fill);
        end
        for (int k = 0; k < 6; k++) begin
            n = ($random(seed) & 7) + 1;
            wr_len[k]  = n;
            wr_addr[k] = ($random(seed) & 32'h7FFF_FFFF) % (MEM_DEPTH - n + 1);
            write_regs(wr_addr[k], n, {$random(seed), $random(seed)});
        end
        for (int k = 0; k < 6; k++) begin
            read_regs(wr_addr[k], wr_len[k]);
        end
        report_test(e0);
    endtask

    task automatic crc_error_frame();
        int         e0;
        logic [7:0] cmd;
        test_name = "bad_crc";
        e0 = errors;
        cmd = 8'(wr_len[0] - 1);
        send_frame(cmd, wr_addr[0], {$random(seed), $random(seed)}, 1'b1);
        collect_resp(ST_CRC_ERR, cmd, wr_addr[0], 64'h0, 1'b1);
        read_regs(wr_addr[0], wr_len[0]);
        report_test(e0);
    endtask

    task automatic bad_frame_status();
        int e0;
        test_name = "frame_errors";
        e0 = errors;
        // Four bytes from two below the top run past the end
        send_frame(8'h03, MEM_DEPTH - 2, 64'hDEAD_BEEF_CAFE_F00D, 1'b0);
        collect_resp(ST_ADDR_ERR, 8'h03, MEM_DEPTH - 2, 64'h0, 1'b1);
        read_regs(MEM_DEPTH - 2, 2);
        send_frame(8'h88, 32'd16, 64'h0, 1'b0);
        collect_resp(ST_CMD_ERR, 8'h88, 32'd16, 64'h0, 1'b1);
        send_byte(8'h00);
        send_byte(8'h3C);
        send_byte(8'hFF);
        read_regs(40, 5);
        report_test(e0);
    endtask

    task automatic fifo_backpressure();
        int e0;
        int waited;
        test_name = "backpressure";
        e0 = errors;
        done_count = 0;
        // Four 16-byte responses against a 16-byte FIFO with nobody reading
        for (int k = 0; k < 4; k++) begin
            send_frame(8'h87, k * 8, 64'h0, 1'b0);
        end
        waited = 0;
        while (rx_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (rx_ready) begin
            $display("%s: rx_ready never fell while the TX FIFO was full", test_name);
            errors++;
        end
        for (int k = 0; k < 4; k++) begin
            collect_resp(ST_OK, 8'h87, k * 8, model_bytes(k * 8, 8), 1'b0);
        end
        repeat (4) @(negedge clk);
        check_byte("frame_done count", 8'd4, 8'(done_count));
        check_byte("tx_empty after drain", 8'h01, {7'b0, tx_empty});
        report_test(e0);
    endtask

    initial begin
        rst          = 1'b1;
        rx_data      = 8'h00;
        rx_valid     = 1'b0;
        tx_rd        = 1'b0;
        seed         = 23;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        done_count   = 0;
        timed_out    = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        idle_after_reset();
        random_write_read();
        crc_error_frame();
        bad_frame_status();
        fifo_backpressure();

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* bridge.f */
source/bridge_pkg.sv
source/crc8_calc.sv
source/cmd_frame_parser.sv
source/reg_executor.sv
source/resp_frame_builder.sv
source/tx_byte_fifo.sv
source/bridge_top.sv
verification/bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module bridge_tb -f bridge.f \
    --Mdir obj_dir -o bridge_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/bridge_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0
